/* Makefile */
# Verilator build and run for the PMA gate testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= pma_gate_tb
FILELIST  ?= pma_gate_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/pma_settings.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not from the exit status
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* pma_gate_top.f */
+incdir+rtl
rtl/mem_access_pkg.sv
rtl/pma_pkg.sv
rtl/access_if.sv
rtl/access_capture.sv
rtl/pma_check.sv
rtl/bus_issue.sv
rtl/pma_gate_top.sv
testbench/pma_gate_tb.sv

/* rtl/access_capture.sv */
// Access capture stage
// Registers the request strobe and flags misaligned accesses

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

module access_capture import mem_access_pkg::*; (
  input  wire logic               clk,
  input  wire logic               rst_i,
  input  wire logic               req_valid_i,
  input  wire logic [`ADDR_W-1:0] req_addr_i,
  input  wire access_kind_e       req_kind_i,
  input  wire access_size_e       req_size_i,
  access_if.producer              acc_o
);

  logic misaligned_d;

  //////////////////////////////////////////////////////////////////////
  // Misalignment
  //////////////////////////////////////////////////////////////////////

  // Byte accesses can never straddle a word
  // Halfword needs bit 0 clear, word needs both low bits clear
  always_comb begin
    case (req_size_i)
      SZ_HALF: misaligned_d = req_addr_i[0];
      SZ_WORD: misaligned_d = |req_addr_i[1:0];
      default: misaligned_d = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////////////////////////

  // Strobe qualifier
  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc_o.valid <= 1'b0;
    end else begin
      acc_o.valid <= req_valid_i;
    end
  end

  // Payload, only meaningful while valid is high
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      acc_o.addr       <= req_addr_i;
      acc_o.kind       <= req_kind_i;
      acc_o.size       <= req_size_i;
      // Precomputed so the check stage sees a single flag
      acc_o.misaligned <= misaligned_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/access_if.sv */
// Access and PMA result interfaces
// Carry one access strobe per cycle between the gate stages

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

// Registered request with its misaligned flag
interface access_if import mem_access_pkg::*; ();
  logic               valid;
  logic [`ADDR_W-1:0] addr;
  access_kind_e       kind;
  access_size_e       size;
  logic               misaligned;

  modport producer (output valid, addr, kind, size, misaligned);
  modport consumer (input valid, addr, kind, size, misaligned);
endinterface

// Checked access with fault flag and bus attributes
interface pma_result_if import mem_access_pkg::*; ();
  logic               valid;
  logic [`ADDR_W-1:0] addr;
  access_kind_e       kind;
  logic               err;
  logic               bufferable;
  logic               cacheable;

  modport producer (output valid, addr, kind, err, bufferable, cacheable);
  modport consumer (input valid, addr, kind, err, bufferable, cacheable);
endinterface

`default_nettype wire

/* rtl/bus_issue.sv */
// Bus issue stage
// Registers each checked access as a bus strobe or a fault pulse and
// keeps the last fault address with a saturating fault count

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

module bus_issue import mem_access_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_i,
  pma_result_if.consumer              res_i,
  output logic                        bus_valid_o,
  output logic [`ADDR_W-1:0]          bus_addr_o,
  output access_kind_e                bus_kind_o,
  output logic                        bus_bufferable_o,
  output logic                        bus_cacheable_o,
  output logic                        fault_o,
  output logic [`ADDR_W-1:0]          fault_addr_o,
  output logic [`FAULT_CNT_W-1:0]     fault_count_o
);

  logic issue;
  logic fault;

  // Each valid result is either issued or faulted, never both
  assign issue = res_i.valid && !res_i.err;
  assign fault = res_i.valid &&  res_i.err;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  // Strobe and attributes
  // Attributes read zero in cycles without an issue
  always_ff @(posedge clk) begin
    if (rst_i) begin
      bus_valid_o      <= 1'b0;
      bus_bufferable_o <= 1'b0;
      bus_cacheable_o  <= 1'b0;
    end else begin
      bus_valid_o      <= issue;
      bus_bufferable_o <= issue && res_i.bufferable;
      bus_cacheable_o  <= issue && res_i.cacheable;
    end
  end

  // Address and kind, held between issues
  always_ff @(posedge clk) begin
    if (issue) begin
      bus_addr_o <= res_i.addr;
      bus_kind_o <= res_i.kind;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fault side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fault_o       <= 1'b0;
      fault_addr_o  <= '0;
      fault_count_o <= '0;
    end else begin
      fault_o <= fault;
      if (fault) begin
        fault_addr_o <= res_i.addr;
        // Count sticks at all ones
        if (fault_count_o != '1) begin
          fault_count_o <= fault_count_o + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_access_pkg.sv */
// Memory access types
// Access kind and size encodings used from capture through to the bus

`default_nettype none

package mem_access_pkg;

  //////////////////////////////////////////////////////////////////////
  // Access kind
  //////////////////////////////////////////////////////////////////////

  // Origin of the access
  // Fetch comes from the fetch unit, load and store from the LSU
  typedef enum logic [1:0] {
    ACC_FETCH = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } access_kind_e;

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  // Number of bytes moved by one access
  // Only half and word can be misaligned
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } access_size_e;

endpackage

`default_nettype wire

/* rtl/pma_check.sv */
// PMA check stage
// Looks up the attribute region of an access and applies the fault,
// bufferable and cacheable rules, all combinational

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

module pma_check import mem_access_pkg::*; import pma_pkg::*; #(
  parameter int          PMA_NUM_REGIONS = `PMA_NUM_REGIONS,
  parameter pma_region_t PMA_CFG [PMA_NUM_REGIONS-1:0] = PMA_CFG_TABLE
) (
  access_if.consumer     acc_i,
  pma_result_if.producer res_o
);

  pma_region_t        region;
  logic [`ADDR_W-1:0] word_addr;
  logic               is_fetch;
  logic               is_store;

  // Table bounds are in words
  assign word_addr = {2'b00, acc_i.addr[`ADDR_W-1:2]};

  //////////////////////////////////////////////////////////////////////
  // Region lookup
  //////////////////////////////////////////////////////////////////////

  generate
    if (PMA_NUM_REGIONS == 0) begin : g_no_pma
      // Deconfigured, every address is main memory
      assign region = NO_PMA_R_DEFAULT;
    end else begin : g_pma
      // Walk from the top entry down so the lowest index match is kept
      always_comb begin
        region = PMA_R_DEFAULT;
        for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
          if ((word_addr >= PMA_CFG[i].word_addr_low) &&
              (word_addr <  PMA_CFG[i].word_addr_high)) begin
            region = PMA_CFG[i];
          end
        end
      end
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Fault and attribute rules
  //////////////////////////////////////////////////////////////////////

  assign is_fetch = (acc_i.kind == ACC_FETCH);
  assign is_store = (acc_i.kind == ACC_STORE);

  // I/O space takes no fetches and no misaligned accesses
  always_comb begin
    res_o.err = 1'b0;
    if (!region.main && is_fetch) begin
      res_o.err = 1'b1;
    end
    if (!region.main && acc_i.misaligned) begin
      res_o.err = 1'b1;
    end
  end

  // Only stores may be posted into a write buffer
  assign res_o.bufferable = region.bufferable && is_store;
  assign res_o.cacheable  = region.cacheable;

  // Access identity passes straight through
  assign res_o.valid = acc_i.valid;
  assign res_o.addr  = acc_i.addr;
  assign res_o.kind  = acc_i.kind;

endmodule

`default_nettype wire

/* rtl/pma_gate_top.sv */
// PMA gate top level
// Capture, region check and bus issue, two cycles from request to bus

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

module pma_gate_top import mem_access_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_i,
  // Request from fetch and LSU
  input  wire logic                   req_valid_i,
  input  wire logic [`ADDR_W-1:0]     req_addr_i,
  input  wire access_kind_e           req_kind_i,
  input  wire access_size_e           req_size_i,
  // Memory bus
  output logic                        bus_valid_o,
  output logic [`ADDR_W-1:0]          bus_addr_o,
  output access_kind_e                bus_kind_o,
  output logic                        bus_bufferable_o,
  output logic                        bus_cacheable_o,
  // Fault report
  output logic                        fault_o,
  output logic [`ADDR_W-1:0]          fault_addr_o,
  output logic [`FAULT_CNT_W-1:0]     fault_count_o
);

  access_if     acc ();
  pma_result_if res ();

  // Cycle 1, register request
  access_capture u_access_capture (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_kind_i  (req_kind_i),
    .req_size_i  (req_size_i),
    .acc_o       (acc.producer)
  );

  // Same cycle, region lookup on the default table
  pma_check u_pma_check (
    .acc_i (acc.consumer),
    .res_o (res.producer)
  );

  // Cycle 2, bus or fault outputs
  bus_issue u_bus_issue (
    .clk              (clk),
    .rst_i            (rst_i),
    .res_i            (res.consumer),
    .bus_valid_o      (bus_valid_o),
    .bus_addr_o       (bus_addr_o),
    .bus_kind_o       (bus_kind_o),
    .bus_bufferable_o (bus_bufferable_o),
    .bus_cacheable_o  (bus_cacheable_o),
    .fault_o          (fault_o),
    .fault_addr_o     (fault_addr_o),
    .fault_count_o    (fault_count_o)
  );

endmodule

`default_nettype wire

/* rtl/pma_pkg.sv */
// PMA region types
// Region attribute record, default regions and the fixed region table

`default_nettype none

`include "pma_settings.svh"

package pma_pkg;

  // One attribute region, bounds are word addresses
  // word_addr_high is exclusive
  typedef struct packed {
    logic [`ADDR_W-1:0] word_addr_low;
    logic [`ADDR_W-1:0] word_addr_high;
    logic               main;
    logic               bufferable;
    logic               cacheable;
  } pma_region_t;

  // Fallback when no region matches: I/O, no buffering, no caching
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0
  };

  // Deconfigured PMA treats all of memory as main
  localparam pma_region_t NO_PMA_R_DEFAULT = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           1'b1,
    bufferable:     1'b0,
    cacheable:      1'b0
  };

  //////////////////////////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////////////////////////

  // Lowest index wins on overlap
  // Entry 3 covers 0x8000..0x4000_FFFF but only shows in the gap above entry 1
  localparam pma_region_t PMA_CFG_TABLE [3:0] = '{
    0: '{32'h0000_0000, 32'h0000_4000, 1'b1, 1'b0, 1'b1},
    1: '{32'h0000_4000, 32'h0000_8000, 1'b1, 1'b1, 1'b0},
    2: '{32'h1000_0000, 32'h1000_4000, 1'b0, 1'b1, 1'b0},
    3: '{32'h0000_2000, 32'h1000_4000, 1'b0, 1'b0, 1'b0}
  };

endpackage

`default_nettype wire

/* rtl/pma_settings.svh */
// PMA gate build settings
// Region count, address width and fault counter width shared by the RTL

`ifndef PMA_SETTINGS_SVH
`define PMA_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Region table
//////////////////////////////////////////////////////////////////////

// Active entries in the attribute table
// 0 deconfigures the PMA, every access is then plain main memory
`define PMA_NUM_REGIONS 4

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Byte address width of the core's memory bus
`define ADDR_W 32

// Saturating fault counter width
`define FAULT_CNT_W 8

`endif

/* testbench/pma_gate_tb.sv */
// PMA gate testbench
// Drives accesses into the gate and checks bus and fault outputs against
// a reference model of the region table, two cycles later

`timescale 1ns/1ps
`default_nettype none

`include "pma_settings.svh"

module pma_gate_tb import mem_access_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////////////////////////

  localparam int CNT_W        = `FAULT_CNT_W;
  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_CYCLES = 3;
  localparam int NUM_TESTS    = 6;
  localparam int RAND_COUNT   = 200;
  localparam int SAT_COUNT    = 260;
  // Directed tests send 4, 4 and 5 accesses
  localparam int NUM_ACCESSES = 13 + RAND_COUNT + SAT_COUNT;
  localparam int WATCHDOG_CYCLES =
    NUM_ACCESSES + RESET_CYCLES + NUM_TESTS * DRAIN_CYCLES + 20;

  // Expected outcome of one access
  typedef struct packed {
    logic               issue;
    logic               fault;
    logic [`ADDR_W-1:0] addr;
    access_kind_e       kind;
    logic               bufferable;
    logic               cacheable;
  } expect_t;

  logic               clk;
  logic               rst_i;
  logic               req_valid_i;
  logic [`ADDR_W-1:0] req_addr_i;
  access_kind_e       req_kind_i;
  access_size_e       req_size_i;
  logic               bus_valid_o;
  logic [`ADDR_W-1:0] bus_addr_o;
  access_kind_e       bus_kind_o;
  logic               bus_bufferable_o;
  logic               bus_cacheable_o;
  logic               fault_o;
  logic [`ADDR_W-1:0] fault_addr_o;
  logic [CNT_W-1:0]   fault_count_o;

  expect_t            exp_q[$];
  expect_t            exp_cur;
  logic [`ADDR_W-1:0] exp_fault_addr;
  logic [CNT_W-1:0]   exp_fault_cnt;
  string              cur_test;
  int                 err_count;
  int                 test_errs_start;
  int                 tests_passed;
  int                 tests_failed;
  integer             seed;

  pma_gate_top dut (
    .clk              (clk),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_kind_i       (req_kind_i),
    .req_size_i       (req_size_i),
    .bus_valid_o      (bus_valid_o),
    .bus_addr_o       (bus_addr_o),
    .bus_kind_o       (bus_kind_o),
    .bus_bufferable_o (bus_bufferable_o),
    .bus_cacheable_o  (bus_cacheable_o),
    .fault_o          (fault_o),
    .fault_addr_o     (fault_addr_o),
    .fault_count_o    (fault_count_o)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Region table in byte addresses, first match in index order wins
  function automatic expect_t model_access(input logic valid, input logic [`ADDR_W-1:0] addr,
                                           input access_kind_e kind, input access_size_e size);
    logic    main_mem;
    logic    bufr;
    logic    cach;
    logic    mis;
    logic    err;
    expect_t e;
    if (addr <= 32'h0000_FFFF) begin
      {main_mem, bufr, cach} = 3'b101;
    end else if (addr >= 32'h0001_0000 && addr <= 32'h0001_FFFF) begin
      {main_mem, bufr, cach} = 3'b110;
    end else if (addr >= 32'h4000_0000 && addr <= 32'h4000_FFFF) begin
      {main_mem, bufr, cach} = 3'b010;
    end else begin
      // Entry 3 gap and unmapped space look the same, plain I/O
      {main_mem, bufr, cach} = 3'b000;
    end
    mis = ((size == SZ_HALF) && addr[0]) || ((size == SZ_WORD) && (addr[1:0] != 2'b00));
    err = !main_mem && ((kind == ACC_FETCH) || mis);
    e.issue      = valid && !err;
    e.fault      = valid && err;
    e.addr       = addr;
    e.kind       = kind;
    e.bufferable = e.issue && bufr && (kind == ACC_STORE);
    e.cacheable  = e.issue && cach;
    return e;
  endfunction

  // Two-cycle delay line, exp_cur lines up with the DUT outputs
  always @(posedge clk) begin
    expect_t head;
    if (rst_i) begin
      exp_q.delete();
      exp_cur        <= '0;
      exp_fault_addr <= '0;
      exp_fault_cnt  <= '0;
    end else begin
      exp_q.push_back(model_access(req_valid_i, req_addr_i, req_kind_i, req_size_i));
      if (exp_q.size() == 2) begin
        head = exp_q.pop_front();
        exp_cur <= head;
        if (head.fault) begin
          exp_fault_addr <= head.addr;
          if (exp_fault_cnt != '1) begin
            exp_fault_cnt <= exp_fault_cnt + CNT_W'(1);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH %s: %s expected 0x%08h actual 0x%08h",
             cur_test, signal, expected, actual);
    err_count = err_count + 1;
  endtask

  a_bus_valid: assert property (@(posedge clk) disable iff (rst_i)
    bus_valid_o == exp_cur.issue)
    else report_mismatch("bus_valid_o", 32'($sampled(exp_cur.issue)),
                         32'($sampled(bus_valid_o)));

  a_fault: assert property (@(posedge clk) disable iff (rst_i)
    fault_o == exp_cur.fault)
    else report_mismatch("fault_o", 32'($sampled(exp_cur.fault)), 32'($sampled(fault_o)));

  // Address and kind only matter while a strobe is out
  a_bus_addr: assert property (@(posedge clk) disable iff (rst_i)
    exp_cur.issue |-> bus_addr_o == exp_cur.addr)
    else report_mismatch("bus_addr_o", $sampled(exp_cur.addr), $sampled(bus_addr_o));

  a_bus_kind: assert property (@(posedge clk) disable iff (rst_i)
    exp_cur.issue |-> bus_kind_o == exp_cur.kind)
    else report_mismatch("bus_kind_o", 32'($sampled(exp_cur.kind)),
                         32'($sampled(bus_kind_o)));

  a_bufferable: assert property (@(posedge clk) disable iff (rst_i)
    bus_bufferable_o == exp_cur.bufferable)
    else report_mismatch("bus_bufferable_o", 32'($sampled(exp_cur.bufferable)),
                         32'($sampled(bus_bufferable_o)));

  a_cacheable: assert property (@(posedge clk) disable iff (rst_i)
    bus_cacheable_o == exp_cur.cacheable)
    else report_mismatch("bus_cacheable_o", 32'($sampled(exp_cur.cacheable)),
                         32'($sampled(bus_cacheable_o)));

  a_fault_addr: assert property (@(posedge clk) disable iff (rst_i)
    fault_addr_o == exp_fault_addr)
    else report_mismatch("fault_addr_o", $sampled(exp_fault_addr), $sampled(fault_addr_o));

  a_fault_count: assert property (@(posedge clk) disable iff (rst_i)
    fault_count_o == exp_fault_cnt)
    else report_mismatch("fault_count_o", 32'($sampled(exp_fault_cnt)),
                         32'($sampled(fault_count_o)));

  a_exclusive: assert property (@(posedge clk) disable iff (rst_i)
    !(bus_valid_o && fault_o))
    else begin
      $display("%s: bus strobe and fault raised in the same cycle", cur_test);
      err_count = err_count + 1;
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // One access for one cycle, inputs change 1 ns after the edge
  task automatic send_access(input logic [`ADDR_W-1:0] addr, input access_kind_e kind,
                             input access_size_e size);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_kind_i  = kind;
    req_size_i  = size;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    test_errs_start = err_count;
  endtask

  // Let the pipe empty, then report the test
  task automatic close_test();
    repeat (DRAIN_CYCLES) @(posedge clk);
    #1;
    if (err_count == test_errs_start) begin
      tests_passed = tests_passed + 1;
      $display("test %-12s PASS", cur_test);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %-12s FAIL (%0d errors)", cur_test, err_count - test_errs_start);
    end
  endtask

  // Random address spread over all regions and the gaps
  task automatic send_random();
    logic [31:0]        r;
    logic [31:0]        pick;
    logic [`ADDR_W-1:0] base;
    r    = $random(seed);
    pick = r % 6;
    case (pick)
      32'd0:   base = 32'h0000_0000;
      32'd1:   base = 32'h0001_0000;
      32'd2:   base = 32'h4000_0000;
      32'd3:   base = 32'h0002_0000;
      32'd4:   base = 32'h8000_0000;
      default: base = 32'h3FFF_0000;
    endcase
    r    = $random(seed);
    base = base + (r & 32'h0000_FFFF);
    r    = $random(seed);
    pick = r % 3;
    r    = $random(seed);
    r    = r % 3;
    send_access(base, access_kind_e'(pick[1:0]), access_size_e'(r[1:0]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed            = 35;
    err_count       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    test_errs_start = 0;
    cur_test        = "reset";
    rst_i           = 1'b1;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_kind_i      = ACC_LOAD;
    req_size_i      = SZ_WORD;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_i = 1'b0;

    start_test("reset");
    assert (bus_valid_o == 1'b0 && fault_o == 1'b0 && fault_count_o == '0)
      else begin
        $display("Bus or fault outputs not idle after reset");
        err_count = err_count + 1;
      end
    close_test();

    start_test("attributes");
    send_access(32'h0000_0100, ACC_LOAD, SZ_WORD);
    send_access(32'h0001_0004, ACC_STORE, SZ_WORD);
    send_access(32'h0001_0008, ACC_LOAD, SZ_WORD);
    send_access(32'h4000_0010, ACC_STORE, SZ_WORD);
    close_test();

    start_test("fetch_fault");
    send_access(32'h4000_0000, ACC_FETCH, SZ_WORD);
    send_access(32'h0002_0000, ACC_FETCH, SZ_WORD);
    send_access(32'h8000_0000, ACC_FETCH, SZ_WORD);
    send_access(32'h0000_0040, ACC_FETCH, SZ_WORD);
    close_test();

    // Odd byte to I/O is still aligned and goes out
    start_test("misaligned");
    send_access(32'h4000_0001, ACC_LOAD, SZ_HALF);
    send_access(32'h4000_0002, ACC_STORE, SZ_WORD);
    send_access(32'h0000_0001, ACC_LOAD, SZ_HALF);
    send_access(32'h0001_0002, ACC_STORE, SZ_WORD);
    send_access(32'h4000_0003, ACC_LOAD, SZ_BYTE);
    close_test();

    start_test("random");
    for (int i = 0; i < RAND_COUNT; i++) begin
      send_random();
    end
    close_test();

    start_test("saturation");
    for (int i = 0; i < SAT_COUNT; i++) begin
      send_access(32'h8000_0000 + (32'(i) << 2), ACC_FETCH, SZ_WORD);
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    #1;
    assert (fault_count_o == '1)
      else report_mismatch("fault_count_o", 32'h0000_00FF, 32'(fault_count_o));
    close_test();

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
